//--- rf_exec_top.f
src/rf_pkg.sv
src/rf_2r1w_sync.sv
src/op_issue.sv
src/alu_writeback.sv
src/rf_exec_top.sv
tb/tb_clk_gen.sv
tb/tb_rf_exec_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register file execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 \
  --top-module tb_rf_exec_top \
  -f rf_exec_top.f \
  -o Vtb_rf_exec_top; then
  echo "verilator build did not complete"
  exit 1
fi

out="$(./obj_dir/Vtb_rf_exec_top)"
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

//--- src/alu_writeback.sv
`timescale 1ns/1ps

module alu_writeback (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // stage 1 from issue
  input  logic             s1_v_i,
  input  rf_pkg::rf_op_t   s1_op_i,
  input  rf_pkg::rf_addr_t s1_rd_i,
  input  rf_pkg::rf_data_t s1_imm_i,

  // operands from register file
  input  rf_pkg::rf_data_t r0_data_i,
  input  rf_pkg::rf_data_t r1_data_i,

  // write port
  output logic             w_v_o,
  output rf_pkg::rf_addr_t w_addr_o,
  output rf_pkg::rf_data_t w_data_o,

  // result report
  output logic             result_v_o,
  output rf_pkg::rf_addr_t result_rd_o,
  output rf_pkg::rf_data_t result_data_o
);

  import rf_pkg::*;

  rf_data_t alu_res;
  logic     alu_ok;

  always_comb
  begin
    alu_res = '0;
    alu_ok  = 1'b1;
    case (s1_op_i)
      OP_LI:   alu_res = s1_imm_i;
      OP_ADD:  alu_res = r0_data_i + r1_data_i;
      OP_SUB:  alu_res = r0_data_i - r1_data_i;  // wraps
      OP_AND:  alu_res = r0_data_i & r1_data_i;
      OP_OR:   alu_res = r0_data_i | r1_data_i;
      OP_XOR:  alu_res = r0_data_i ^ r1_data_i;
      default:
      begin
        alu_ok = 1'b0;
      end
    endcase
  end

  // write commits at the edge closing stage 1
  assign w_v_o    = s1_v_i & alu_ok;
  assign w_addr_o = s1_rd_i;
  assign w_data_o = alu_res;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      result_v_o <= 1'b0;
    end
    else
    begin
      result_v_o <= w_v_o;
    end
  end

  // result payload holds between strobes
  always_ff @(posedge clk_i)
  begin
    if (w_v_o)
    begin
      result_rd_o   <= s1_rd_i;
      result_data_o <= alu_res;
    end
  end

endmodule

//--- src/op_issue.sv
`timescale 1ns/1ps

module op_issue (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // incoming instruction
  input  logic             instr_v_i,
  input  rf_pkg::rf_op_t   instr_op_i,
  input  rf_pkg::rf_addr_t instr_rd_i,
  input  rf_pkg::rf_addr_t instr_rs1_i,
  input  rf_pkg::rf_addr_t instr_rs2_i,
  input  rf_pkg::rf_data_t instr_imm_i,

  // register file read requests
  output logic             r0_v_o,
  output rf_pkg::rf_addr_t r0_addr_o,
  output logic             r1_v_o,
  output rf_pkg::rf_addr_t r1_addr_o,

  // stage 1
  output logic             s1_v_o,
  output rf_pkg::rf_op_t   s1_op_o,
  output rf_pkg::rf_addr_t s1_rd_o,
  output rf_pkg::rf_data_t s1_imm_o
);

  import rf_pkg::*;

  logic needs_rs;  // opcode reads rs1 and rs2
  logic op_ok;     // opcode produces a result

  always_comb
  begin
    needs_rs = 1'b0;
    op_ok    = 1'b1;
    case (instr_op_i)
      OP_LI:
      begin
        needs_rs = 1'b0;
      end
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
      begin
        needs_rs = 1'b1;
      end
      default:
      begin
        op_ok = 1'b0;
      end
    endcase
  end

  // reads go out in the same cycle the instruction is sampled
  assign r0_v_o    = instr_v_i & needs_rs;
  assign r1_v_o    = instr_v_i & needs_rs;
  assign r0_addr_o = instr_rs1_i;
  assign r1_addr_o = instr_rs2_i;

  // no-ops never reach stage 1
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_o <= 1'b0;
    end
    else
    begin
      s1_v_o <= instr_v_i & op_ok;
    end
  end

  // payload lines up with read data
  always_ff @(posedge clk_i)
  begin
    if (instr_v_i)
    begin
      s1_op_o  <= instr_op_i;
      s1_rd_o  <= instr_rd_i;
      s1_imm_o <= instr_imm_i;
    end
  end

endmodule

//--- src/rf_2r1w_sync.sv
`timescale 1ns/1ps

module rf_2r1w_sync #(
  parameter int read_write_same_addr_p = 0
) (
  input  logic             clk_i,

  input  logic             w_v_i,
  input  rf_pkg::rf_addr_t w_addr_i,
  input  rf_pkg::rf_data_t w_data_i,

  input  logic             r0_v_i,
  input  rf_pkg::rf_addr_t r0_addr_i,
  output rf_pkg::rf_data_t r0_data_o,

  input  logic             r1_v_i,
  input  rf_pkg::rf_addr_t r1_addr_i,
  output rf_pkg::rf_data_t r1_data_o
);

  import rf_pkg::*;

  localparam int N_RD = 2;

  // storage, no reset on the array
  rf_data_t mem [REGS];

  logic     r_v    [N_RD];
  rf_addr_t r_addr [N_RD];
  rf_data_t r_data [N_RD];

  // fold the two read ports into arrays
  assign r_v[0]    = r0_v_i;
  assign r_v[1]    = r1_v_i;
  assign r_addr[0] = r0_addr_i;
  assign r_addr[1] = r1_addr_i;

  assign r0_data_o = r_data[0];
  assign r1_data_o = r_data[1];

  // single write port
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem[w_addr_i] <= w_data_i;
    end
  end

  for (genvar p = 0; p < N_RD; p++)
  begin : g_rd
    logic fwd;

    // write-first on same address when enabled
    assign fwd = (read_write_same_addr_p != 0) && w_v_i && (w_addr_i == r_addr[p]);

    // output holds while strobe is low
    always_ff @(posedge clk_i)
    begin
      if (r_v[p])
      begin
        if (fwd)
        begin
          r_data[p] <= w_data_i;
        end
        else
        begin
          r_data[p] <= mem[r_addr[p]];
        end
      end
    end
  end

endmodule

//--- src/rf_exec_top.sv
`timescale 1ns/1ps

module rf_exec_top #(
  parameter int read_write_same_addr_p = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  logic             instr_v_i,
  input  rf_pkg::rf_op_t   instr_op_i,
  input  rf_pkg::rf_addr_t instr_rd_i,
  input  rf_pkg::rf_addr_t instr_rs1_i,
  input  rf_pkg::rf_addr_t instr_rs2_i,
  input  rf_pkg::rf_data_t instr_imm_i,

  output logic             result_v_o,
  output rf_pkg::rf_addr_t result_rd_o,
  output rf_pkg::rf_data_t result_data_o
);

  import rf_pkg::*;

  // read requests
  logic     r0_v;
  logic     r1_v;
  rf_addr_t r0_addr;
  rf_addr_t r1_addr;
  rf_data_t r0_data;
  rf_data_t r1_data;

  // stage 1
  logic     s1_v;
  rf_op_t   s1_op;
  rf_addr_t s1_rd;
  rf_data_t s1_imm;

  // writeback
  logic     w_v;
  rf_addr_t w_addr;
  rf_data_t w_data;

  op_issue u_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_v_i   (instr_v_i),
    .instr_op_i  (instr_op_i),
    .instr_rd_i  (instr_rd_i),
    .instr_rs1_i (instr_rs1_i),
    .instr_rs2_i (instr_rs2_i),
    .instr_imm_i (instr_imm_i),
    .r0_v_o      (r0_v),
    .r0_addr_o   (r0_addr),
    .r1_v_o      (r1_v),
    .r1_addr_o   (r1_addr),
    .s1_v_o      (s1_v),
    .s1_op_o     (s1_op),
    .s1_rd_o     (s1_rd),
    .s1_imm_o    (s1_imm)
  );

  rf_2r1w_sync #(
    .read_write_same_addr_p (read_write_same_addr_p)
  ) u_rf (
    .clk_i     (clk_i),
    .w_v_i     (w_v),
    .w_addr_i  (w_addr),
    .w_data_i  (w_data),
    .r0_v_i    (r0_v),
    .r0_addr_i (r0_addr),
    .r0_data_o (r0_data),
    .r1_v_i    (r1_v),
    .r1_addr_i (r1_addr),
    .r1_data_o (r1_data)
  );

  alu_writeback u_alu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .s1_v_i        (s1_v),
    .s1_op_i       (s1_op),
    .s1_rd_i       (s1_rd),
    .s1_imm_i      (s1_imm),
    .r0_data_i     (r0_data),
    .r1_data_i     (r1_data),
    .w_v_o         (w_v),
    .w_addr_o      (w_addr),
    .w_data_o      (w_data),
    .result_v_o    (result_v_o),
    .result_rd_o   (result_rd_o),
    .result_data_o (result_data_o)
  );

endmodule

//--- src/rf_pkg.sv
package rf_pkg;

  // register file geometry
  localparam int DATA_W = 32;
  localparam int REGS   = 16;
  localparam int ADDR_W = $clog2(REGS);
  localparam int OP_W   = 3;

  typedef logic [DATA_W-1:0] rf_data_t;
  typedef logic [ADDR_W-1:0] rf_addr_t;
  typedef logic [OP_W-1:0]   rf_op_t;

  // opcodes, 6 and 7 decode as no-op
  localparam rf_op_t OP_LI  = 3'd0;  // rd = imm
  localparam rf_op_t OP_ADD = 3'd1;
  localparam rf_op_t OP_SUB = 3'd2;  // wraps mod 2^32
  localparam rf_op_t OP_AND = 3'd3;
  localparam rf_op_t OP_OR  = 3'd4;
  localparam rf_op_t OP_XOR = 3'd5;

endpackage

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_p     = 4.0,
  parameter int  rst_cycles_p = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(period_p / 2.0);
      clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (rst_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb/tb_rf_exec_top.sv
`timescale 1ns/1ps

module tb_rf_exec_top;

  import rf_pkg::*;

  localparam int RESET_LIMIT = 64;
  localparam int DRAIN_LIMIT = 20;
  localparam int N_RANDOM    = 200;

  typedef struct packed {
    rf_op_t   op;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_data_t imm;
    rf_data_t exp;
  } row_t;

  typedef struct packed {
    rf_addr_t rd;
    rf_data_t data;
    int       due;  // edge count at which the strobe must be seen
  } exp_t;

  logic     clk;
  logic     rst_n;
  logic     instr_v;
  rf_op_t   instr_op;
  rf_addr_t instr_rd;
  rf_addr_t instr_rs1;
  rf_addr_t instr_rs2;
  rf_data_t instr_imm;
  logic     result_v;
  rf_addr_t result_rd;
  rf_data_t result_data;

  rf_data_t shadow [REGS];
  row_t     rows [$];
  exp_t     exp_q [$];
  exp_t     front;
  int       edge_cnt  = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rf_exec_top #(
    .read_write_same_addr_p (1)
  ) UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_v_i     (instr_v),
    .instr_op_i    (instr_op),
    .instr_rd_i    (instr_rd),
    .instr_rs1_i   (instr_rs1),
    .instr_rs2_i   (instr_rs2),
    .instr_imm_i   (instr_imm),
    .result_v_o    (result_v),
    .result_rd_o   (result_rd),
    .result_data_o (result_data)
  );

  always @(posedge clk)
  begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic report_fail();
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input rf_data_t got, input rf_data_t exp, input string name);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_reg(input rf_addr_t got, input rf_addr_t exp, input string name);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  // opcode rule, codes above xor are no-ops
  function automatic rf_data_t predict(input rf_op_t op, input rf_data_t a, input rf_data_t b,
                                       input rf_data_t imm);
    case (op)
      OP_LI:   return imm;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  task automatic add_row(input rf_op_t op, input rf_addr_t rd, input rf_addr_t rs1,
                         input rf_addr_t rs2, input rf_data_t imm, input rf_data_t exp);
    row_t r;
    r.op  = op;
    r.rd  = rd;
    r.rs1 = rs1;
    r.rs2 = rs2;
    r.imm = imm;
    r.exp = exp;
    rows.push_back(r);
  endtask

  // drive one instruction for one cycle, update the model
  task automatic issue(input rf_op_t op, input rf_addr_t rd, input rf_addr_t rs1,
                       input rf_addr_t rs2, input rf_data_t imm, output rf_data_t pred);
    exp_t e;
    instr_v   = 1'b1;
    instr_op  = op;
    instr_rd  = rd;
    instr_rs1 = rs1;
    instr_rs2 = rs2;
    instr_imm = imm;
    pred = predict(op, shadow[rs1], shadow[rs2], imm);
    if (op <= OP_XOR)
    begin
      shadow[rd] = pred;
      e.rd   = rd;
      e.data = pred;
      e.due  = edge_cnt + 2;
      exp_q.push_back(e);
    end
    @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    instr_v = 1'b0;
    waited  = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout: %0d results never arrived", exp_q.size());
      report_fail();
    end
  endtask

  // result monitor, outputs are stable on the falling edge
  always @(negedge clk)
  begin
    if (edge_cnt > 0)
    begin
      if (result_v === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          $display("result strobe at %0t ns with no instruction outstanding", $time);
          report_fail();
        end
        else
        begin
          front = exp_q.pop_front();
          if (edge_cnt != front.due)
          begin
            $display("result for r%0d came at edge %0d instead of edge %0d",
                     front.rd, edge_cnt, front.due);
            report_fail();
          end
          check_reg(result_rd, front.rd, "result_rd_o");
          check_data(result_data, front.data, "result_data_o");
        end
      end
      else if (result_v !== 1'b0)
      begin
        $display("result_v_o is unknown at %0t ns", $time);
        report_fail();
      end
      else if (exp_q.size() != 0 && exp_q[0].due <= edge_cnt)
      begin
        $display("no result strobe for r%0d two cycles after issue", exp_q[0].rd);
        report_fail();
      end
    end
  end

  initial
  begin
    rf_data_t pred;
    int       waited;
    instr_v   = 1'b0;
    instr_op  = OP_LI;
    instr_rd  = '0;
    instr_rs1 = '0;
    instr_rs2 = '0;
    instr_imm = '0;
    void'($urandom(32'he4bf_7250));

    // load every register first
    add_row(OP_LI,  4'd0,  4'd0,  4'd0,  32'h0000_0005, 32'h0000_0005);
    add_row(OP_LI,  4'd1,  4'd0,  4'd0,  32'h0000_0003, 32'h0000_0003);
    add_row(OP_LI,  4'd2,  4'd0,  4'd0,  32'hffff_ffff, 32'hffff_ffff);
    add_row(OP_LI,  4'd3,  4'd0,  4'd0,  32'h8000_0000, 32'h8000_0000);
    add_row(OP_LI,  4'd4,  4'd0,  4'd0,  32'h1234_5678, 32'h1234_5678);
    add_row(OP_LI,  4'd5,  4'd0,  4'd0,  32'h0f0f_0f0f, 32'h0f0f_0f0f);
    add_row(OP_LI,  4'd6,  4'd0,  4'd0,  32'hf0f0_f0f0, 32'hf0f0_f0f0);
    add_row(OP_LI,  4'd7,  4'd0,  4'd0,  32'h0000_0001, 32'h0000_0001);
    add_row(OP_LI,  4'd8,  4'd0,  4'd0,  32'hdead_beef, 32'hdead_beef);
    add_row(OP_LI,  4'd9,  4'd0,  4'd0,  32'h0000_0000, 32'h0000_0000);
    add_row(OP_LI,  4'd10, 4'd0,  4'd0,  32'haaaa_5555, 32'haaaa_5555);
    add_row(OP_LI,  4'd11, 4'd0,  4'd0,  32'h5555_aaaa, 32'h5555_aaaa);
    add_row(OP_LI,  4'd12, 4'd0,  4'd0,  32'h7fff_ffff, 32'h7fff_ffff);
    add_row(OP_LI,  4'd13, 4'd0,  4'd0,  32'h0000_0010, 32'h0000_0010);
    add_row(OP_LI,  4'd14, 4'd0,  4'd0,  32'hcafe_f00d, 32'hcafe_f00d);
    add_row(OP_LI,  4'd15, 4'd0,  4'd0,  32'h0000_0100, 32'h0000_0100);
    add_row(OP_ADD, 4'd9,  4'd0,  4'd1,  32'h0,         32'h0000_0008);
    add_row(OP_SUB, 4'd13, 4'd1,  4'd0,  32'h0,         32'hffff_fffe);  // wraps
    add_row(OP_SUB, 4'd12, 4'd9,  4'd9,  32'h0,         32'h0000_0000);
    add_row(OP_ADD, 4'd3,  4'd3,  4'd3,  32'h0,         32'h0000_0000);
    add_row(OP_AND, 4'd8,  4'd8,  4'd5,  32'h0,         32'h0e0d_0e0f);
    add_row(OP_OR,  4'd10, 4'd5,  4'd6,  32'h0,         32'hffff_ffff);
    add_row(OP_XOR, 4'd11, 4'd4,  4'd2,  32'h0,         32'hedcb_a987);
    add_row(OP_XOR, 4'd4,  4'd4,  4'd4,  32'h0,         32'h0000_0000);
    add_row(OP_AND, 4'd6,  4'd14, 4'd2,  32'h0,         32'hcafe_f00d);
    // dependent chain, each reads the previous destination
    add_row(OP_ADD, 4'd7,  4'd7,  4'd7,  32'h0,         32'h0000_0002);
    add_row(OP_ADD, 4'd7,  4'd7,  4'd7,  32'h0,         32'h0000_0004);
    add_row(OP_SUB, 4'd15, 4'd15, 4'd7,  32'h0,         32'h0000_00fc);
    add_row(OP_XOR, 4'd15, 4'd15, 4'd14, 32'h0,         32'hcafe_f0f1);
    add_row(OP_OR,  4'd0,  4'd15, 4'd1,  32'h0,         32'hcafe_f0f3);
    add_row(OP_SUB, 4'd1,  4'd1,  4'd0,  32'h0,         32'h3501_0f10);
    add_row(OP_LI,  4'd2,  4'd0,  4'd0,  32'h0000_0042, 32'h0000_0042);
    add_row(OP_ADD, 4'd5,  4'd2,  4'd2,  32'h0,         32'h0000_0084);
    // no-ops must not touch r9 or r12
    add_row(3'd6,   4'd9,  4'd0,  4'd1,  32'h1111_1111, 32'h0);
    add_row(3'd7,   4'd12, 4'd0,  4'd1,  32'h2222_2222, 32'h0);
    add_row(OP_OR,  4'd14, 4'd9,  4'd12, 32'h0,         32'h0000_0008);

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("timeout: reset never released");
      report_fail();
    end
    @(negedge clk);

    for (int i = 0; i < rows.size(); i++)
    begin
      issue(rows[i].op, rows[i].rd, rows[i].rs1, rows[i].rs2, rows[i].imm, pred);
      if (rows[i].op <= OP_XOR)
      begin
        check_data(pred, rows[i].exp, "shadow model vs table");
      end
    end
    drain();

    // random traffic, one instruction per cycle
    for (int n = 0; n < N_RANDOM; n++)
    begin
      issue(rf_op_t'($urandom_range(0, 7)), rf_addr_t'($urandom_range(0, REGS - 1)),
            rf_addr_t'($urandom_range(0, REGS - 1)), rf_addr_t'($urandom_range(0, REGS - 1)),
            rf_data_t'($urandom()), pred);
    end
    drain();

    $display("sim passed");
    $finish;
  end

endmodule
